// File: design/framebuffer.sv
// framebuffer fetcher
// Reads four bit planes per 8-pixel column from the SRAM in video slices
// and unpacks them into 4-bit palette indices for the line store.

`include "video_consts.svh"

module framebuffer import video_pkg::*; (
	input  logic        clk24,
	input  logic        rst,
	input  logic        row_start,
	input  logic [8:0]  fb_row,
	input  logic [7:0]  scroll,
	input  logic        video_slice,
	input  logic [7:0]  sram_dq,
	output logic [15:0] sram_addr,
	output lb_write_t   lb_wr
);

	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_UNPACK} fetch_state_t;

	fetch_state_t    state;
	logic [4:0]      col;
	logic [1:0]      plane;
	logic [2:0]      pix;
	// active line being fetched, scroll already applied
	logic [7:0]      line;
	logic            bank;
	// byte k holds plane k, shifted left while unpacking
	logic [3:0][7:0] plane_bytes;
	logic [8:0]      next_row;
	logic            next_active;

	// the fetch always works one row ahead of the display
	assign next_row    = fb_row + 9'd1;
	assign next_active = (next_row >= 9'(`V_ACT_START)) && (next_row < 9'(`V_ACT_END));

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk24) begin
		if (rst) begin
			state <= S_IDLE;
			col   <= '0;
			plane <= '0;
			pix   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (row_start && next_active) begin
						state <= S_FETCH;
						col   <= '0;
						plane <= '0;
					end
				end
				S_FETCH: begin
					// stall here until memory gives us a slice
					if (video_slice) begin
						plane <= plane + 2'd1;
						if (plane == 2'd3) begin
							state <= S_UNPACK;
							pix   <= '0;
						end
					end
				end
				S_UNPACK: begin
					pix <= pix + 3'd1;
					if (pix == 3'd7) begin
						// column 31 closes the row
						if (col == 5'd31) begin
							state <= S_IDLE;
						end else begin
							col   <= col + 5'd1;
							state <= S_FETCH;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge clk24) begin
		if (state == S_IDLE && row_start) begin
			line <= next_row[7:0] - 8'(`V_ACT_START) + scroll;
			bank <= next_row[0];
		end
		if (state == S_FETCH && video_slice)
			plane_bytes <= {sram_dq, plane_bytes[3:1]};
		if (state == S_UNPACK) begin
			for (int k = 0; k < 4; k++)
				plane_bytes[k] <= {plane_bytes[k][6:0], 1'b0};
		end
	end

	// plane number rides on top of the base, column in the middle
	assign sram_addr = (state == S_FETCH) ?
		{`PLANE_BASE + {1'b0, plane}, col, line} : 16'd0;

	// msb of every plane byte is the leftmost pixel
	always_comb begin
		lb_wr.we   = (state == S_UNPACK);
		lb_wr.bank = bank;
		lb_wr.addr = {col, pix};
		for (int k = 0; k < 4; k++)
			lb_wr.data[k] = plane_bytes[k][7];
	end

	// a row must be complete before the refresh asks for the next one
	a_fetch_done: assert property (@(posedge clk24) disable iff (rst)
		row_start |-> (state == S_IDLE))
		else $error("fetch still busy at row_start");

endmodule

// File: design/line_buffer.sv
// line store bank
// One row of palette indices with a write port from the fetcher and a
// registered read port for the display side.

module line_buffer import video_pkg::*; #(
	parameter int DEPTH = 256
) (
	input  logic       clk24,
	input  logic       we,
	input  logic [7:0] waddr,
	input  logic [7:0] raddr,
	input  color_idx_t wdata,
	output color_idx_t rdata
);

	// ------------------------------
	// storage
	// ------------------------------
	// one index per pixel column
	color_idx_t mem [DEPTH];

	// write side
	// fed from the unpacker at one pixel per clock
	always_ff @(posedge clk24) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// ------------------------------
	// read side
	// ------------------------------
	// one clock of latency
	// the scan doubler delays timing to match
	always_ff @(posedge clk24) begin
		rdata <= mem[raddr];
	end

endmodule

// File: design/scan_doubler.sv
// scan doubler
// Two line store banks in ping-pong. One is filled by the fetcher while
// the other is shown on both VGA lines of a row. Picks border or picture.

`include "video_consts.svh"

module scan_doubler import video_pkg::*; (
	input  logic          clk24,
	input  logic          rst,
	input  video_timing_t timing,
	input  lb_write_t     lb_wr,
	input  color_idx_t    border_idx,
	output video_timing_t timing_out,
	output color_idx_t    coloridx
);

	// read data of both banks
	color_idx_t rd [2];

	// ------------------------------
	// banks
	// ------------------------------
	for (genvar b = 0; b < 2; b++) begin : g_bank
		line_buffer #(
			.DEPTH(`LINE_PIXELS)
		) u_bank (
			.clk24(clk24),
			// write lands only in the bank the fetcher names
			.we(lb_wr.we && (lb_wr.bank == 1'(b))),
			.waddr(lb_wr.addr),
			.raddr(timing.pixel_x),
			.wdata(lb_wr.data),
			.rdata(rd[b])
		);
	end

	// timing follows the read by one clock
	always_ff @(posedge clk24) begin
		if (rst)
			timing_out <= TIMING_IDLE;
		else
			timing_out <= timing;
	end

	// picture inside active, border in the rest of the window
	// black elsewhere
	always_comb begin
		if (timing_out.in_active)
			coloridx = rd[timing_out.row_parity];
		else if (timing_out.in_window)
			coloridx = border_idx;
		else
			coloridx = '0;
	end

	// fetcher must stay off the bank on screen
	a_bank_split: assert property (@(posedge clk24) disable iff (rst)
		(lb_wr.we && timing.in_active) |-> (lb_wr.bank != timing.row_parity))
		else $error("line store write hit the displayed bank");

endmodule

// File: design/vga_refresh.sv
// VGA refresh generator
// 768 clocks per line, 624 lines per frame, every framebuffer row doubled.
// Derives syncs, border and picture windows and the row strobe,
// and latches the scroll register once per frame.

`include "video_consts.svh"

module vga_refresh import video_pkg::*; (
	input  logic          clk24,
	input  logic          rst,
	input  logic [7:0]    video_scroll_reg,
	output video_timing_t timing,
	output logic [8:0]    fb_row,
	output logic [7:0]    scroll
);

	logic [9:0]    hcount;
	// VGA line within the frame
	logic [9:0]    vline;
	logic [8:0]    row;
	// clocks since the first pixel
	logic [9:0]    hx;
	logic          hwin;
	logic          vwin;
	logic          hact;
	logic          vact;
	video_timing_t timing_d;

	// two VGA lines per framebuffer row
	assign row = vline[9:1];
	assign hx  = hcount - 10'(`H_ACT_START);

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge clk24) begin
		if (rst) begin
			hcount <= '0;
			vline  <= '0;
		end else if (hcount == 10'(`H_TOTAL - 1)) begin
			hcount <= '0;
			// frame wraps after the last line of the last row
			if (vline == 10'(2 * `V_ROWS - 1))
				vline <= '0;
			else
				vline <= vline + 10'd1;
		end else begin
			hcount <= hcount + 10'd1;
		end
	end

	// ------------------------------
	// windows and strobes
	// ------------------------------
	always_comb begin
		hwin = (hcount >= 10'(`H_WIN_START)) && (hcount < 10'(`H_WIN_END));
		vwin = (row >= 9'(`V_WIN_START)) && (row < 9'(`V_WIN_END));
		hact = (hcount >= 10'(`H_ACT_START)) && (hcount < 10'(`H_ACT_END));
		vact = (row >= 9'(`V_ACT_START)) && (row < 9'(`V_ACT_END));

		timing_d.hsync      = (hcount >= 10'(`H_SYNC));
		timing_d.vsync      = (row >= 9'(`V_SYNC_ROWS));
		timing_d.in_window  = hwin && vwin;
		timing_d.in_active  = hact && vact;
		timing_d.retrace    = !vact;
		timing_d.pixel_x    = hx[8:1];
		// only the even line of a pair starts a fetch
		timing_d.row_start  = (hcount == 10'd0) && !vline[0];
		timing_d.row_parity = row[0];
	end

	// everything leaves one clock after the counters
	always_ff @(posedge clk24) begin
		if (rst) begin
			timing <= TIMING_IDLE;
			fb_row <= '0;
		end else begin
			timing <= timing_d;
			fb_row <= row;
		end
	end

	// scroll is taken at the top of the frame and held until the next one
	always_ff @(posedge clk24) begin
		if (rst)
			scroll <= '0;
		else if (hcount == 10'd0 && vline == 10'd0)
			scroll <= video_scroll_reg;
	end

	// line counter never runs past the end of a line
	a_hcount_range: assert property (@(posedge clk24) disable iff (rst)
		hcount < 10'(`H_TOTAL))
		else $error("hcount reached H_TOTAL");

endmodule

// File: design/video_pkg.sv
// video types
// colour, timing and line store write types shared by the video block

package video_pkg;

	// palette index as stored in the line store
	typedef logic [3:0] color_idx_t;

	// real colour from the palette RAM, goes straight to the DAC
	typedef logic [7:0] rgb_t;

	// ------------------------------
	// timing bundle from vga_refresh
	// ------------------------------
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		// inside the border window
		logic       in_window;
		// inside the 256x256 picture
		logic       in_active;
		// row outside the active rows
		logic       retrace;
		// pixel column, only meaningful while in_active
		logic [7:0] pixel_x;
		// one clock at the start of a row pair
		logic       row_start;
		// picks the line store bank being shown
		logic       row_parity;
	} video_timing_t;

	// idle value, syncs inactive and retrace up
	localparam video_timing_t TIMING_IDLE = '{
		hsync: 1'b1, vsync: 1'b1, in_window: 1'b0, in_active: 1'b0,
		retrace: 1'b1, pixel_x: 8'd0, row_start: 1'b0, row_parity: 1'b0};

	// one index write from the fetcher into a line store bank
	typedef struct packed {
		logic       we;
		logic       bank;
		logic [7:0] addr;
		color_idx_t data;
	} lb_write_t;

endpackage

// File: design/video_top.sv
// video block top
// VGA refresh, framebuffer fetch and scan doubler. The palette RAM is
// outside. coloridx addresses it and realcolor_in comes back from it.

module video_top import video_pkg::*; (
	input  logic        clk24,
	input  logic        rst,
	input  logic        video_slice,
	input  logic [7:0]  video_scroll_reg,
	input  color_idx_t  border_idx,
	input  logic [7:0]  sram_dq,
	output logic [15:0] sram_addr,
	output logic        hsync,
	output logic        vsync,
	output logic        retrace,
	output color_idx_t  coloridx,
	input  rgb_t        realcolor_in,
	output rgb_t        realcolor_out
);

	video_timing_t timing;
	video_timing_t timing_out;
	logic [8:0]    fb_row;
	logic [7:0]    scroll;
	lb_write_t     lb_wr;

	// ------------------------------
	// frame timing
	// ------------------------------
	vga_refresh u_refresh (
		.clk24(clk24),
		.rst(rst),
		.video_scroll_reg(video_scroll_reg),
		.timing(timing),
		.fb_row(fb_row),
		.scroll(scroll)
	);

	// SRAM to line store
	framebuffer u_fetch (
		.clk24(clk24),
		.rst(rst),
		.row_start(timing.row_start),
		.fb_row(fb_row),
		.scroll(scroll),
		.video_slice(video_slice),
		.sram_dq(sram_dq),
		.sram_addr(sram_addr),
		.lb_wr(lb_wr)
	);

	scan_doubler u_doubler (
		.clk24(clk24),
		.rst(rst),
		.timing(timing),
		.lb_wr(lb_wr),
		.border_idx(border_idx),
		.timing_out(timing_out),
		.coloridx(coloridx)
	);

	// ------------------------------
	// outputs
	// ------------------------------
	// all outputs share the same two clock delay
	assign hsync   = timing_out.hsync;
	assign vsync   = timing_out.vsync;
	assign retrace = timing_out.retrace;

	// palette answers combinationally so its colour lines up with coloridx
	assign realcolor_out = timing_out.in_window ? realcolor_in : '0;

endmodule

// File: include/video_consts.svh
// video timing constants
// line, frame, window and SRAM address map for the scan doubled VGA block
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ------------------------------
// horizontal, in 24 MHz clocks
// ------------------------------
// one full VGA line
`define H_TOTAL      768
// hsync is low for the first clocks of a line
`define H_SYNC       64
// border window, end is exclusive
`define H_WIN_START  64
`define H_WIN_END    704
// pixel 0 starts here, each pixel lasts two clocks
`define H_ACT_START  128
`define LINE_PIXELS  256
`define H_ACT_END    (`H_ACT_START + 2 * `LINE_PIXELS)

// ------------------------------
// vertical, in framebuffer rows
// ------------------------------
// every row is shown on two VGA lines
`define V_ROWS       312
`define V_SYNC_ROWS  3
`define V_WIN_START  8
`define V_WIN_END    304
`define V_ACT_START  40
`define V_ACT_END    (`V_ACT_START + `LINE_PIXELS)

// plane p lives at address bits 15:13 = PLANE_BASE + p
`define PLANE_BASE   3'b100

`endif

// File: run_sim.sh
#!/bin/sh
# builds the video block testbench with Verilator and runs it
# a run that exits with an error gets the failure line appended to its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vector_video.f --top-module tb_video -o tb_video \
	|| { echo "build failed"; exit 1; }
./obj_dir/tb_video > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
echo "simulation passed"
exit 0

// File: tests/sram_model.sv
// SRAM model
// 64 KiB of asynchronous read memory for the framebuffer fetcher.
// Filled with seeded random bytes before the run.

module sram_model (
	input  logic [15:0] addr,
	output logic [7:0]  dq
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] mem [65536];

	// data follows the address with no clock
	assign dq = mem[addr];

	// every byte gets its own draw from the seeded generator
	task automatic preload(input int seed_in);
		int seed;
		int word;
		seed = seed_in;
		for (int a = 0; a < 65536; a++) begin
			word = $random(seed);
			mem[16'(a)] = word[7:0];
		end
	endtask

	// reference read for expected pixels
	function automatic logic [7:0] lookup(input logic [15:0] a);
		return mem[a];
	endfunction

endmodule

// File: tests/tb_video.sv
// video block testbench
// Directed tests for sync timing, retrace, border, pixels, fetch order,
// scan doubling and scroll. The SRAM model holds random bit planes and
// the palette model answers combinationally from coloridx.

`include "video_consts.svh"

module tb_video import video_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// one frame is 624 VGA lines
	localparam int FRAME_CLOCKS = `H_TOTAL * 2 * `V_ROWS;
	// ten frames, the tests need a little under nine
	localparam int TIMEOUT_CYCLES = 10 * FRAME_CLOCKS;

	logic        clk24;
	logic        rst;
	logic        video_slice = 1'b0;
	logic [7:0]  video_scroll_reg;
	color_idx_t  border_idx;
	logic [7:0]  sram_dq;
	logic [15:0] sram_addr;
	logic        hsync;
	logic        vsync;
	logic        retrace;
	color_idx_t  coloridx;
	rgb_t        realcolor_in;
	rgb_t        realcolor_out;
	logic [1:0]  slice_phase = 2'd0;
	int          cycles = 0;
	int          checks = 0;
	// VGA line of the frame at the current sample
	int          cur_line = 0;
	int          seed = 32'hf634_addd;

	// ------------------------------
	// clock, slices, palette, DUT
	// ------------------------------
	initial begin
		clk24 = 1'b0;
		forever #20 clk24 = ~clk24;
	end

	// memory slice every fourth clock
	always @(posedge clk24) begin
		slice_phase <= slice_phase + 2'd1;
		video_slice <= (slice_phase == 2'd3);
	end

	// palette RAM: index on top, inverted index below
	assign realcolor_in = palette(coloridx);

	video_top DUT (
		.clk24(clk24),
		.rst(rst),
		.video_slice(video_slice),
		.video_scroll_reg(video_scroll_reg),
		.border_idx(border_idx),
		.sram_dq(sram_dq),
		.sram_addr(sram_addr),
		.hsync(hsync),
		.vsync(vsync),
		.retrace(retrace),
		.coloridx(coloridx),
		.realcolor_in(realcolor_in),
		.realcolor_out(realcolor_out)
	);

	sram_model mem_model (
		.addr(sram_addr),
		.dq(sram_dq)
	);

	// run limit
	always @(posedge clk24) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_run($sformatf("timeout, run still busy after %0d clocks", cycles));
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic rgb_t palette(input color_idx_t idx);
		return {idx, ~idx};
	endfunction

	function automatic logic sync_level(input bit use_v);
		return use_v ? vsync : hsync;
	endfunction

	// bit k of the index comes from plane k, leftmost pixel in the msb
	function automatic color_idx_t expect_pixel(input int row, input int x,
			input logic [7:0] scr);
		logic [7:0]  line;
		logic [15:0] addr;
		logic [7:0]  plane_byte;
		logic [2:0]  j;
		color_idx_t  idx;
		line = 8'(row - `V_ACT_START + int'(scr));
		j = 3'(7 - x % 8);
		for (int k = 0; k < 4; k++) begin
			addr = {3'(`PLANE_BASE + k), 5'(x / 8), line};
			plane_byte = mem_model.lookup(addr);
			idx[k] = plane_byte[j];
		end
		return idx;
	endfunction

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// outputs are read half a clock after the edge that moved them
	task automatic tick();
		@(negedge clk24);
	endtask

	task automatic wait_fall(input bit use_v, input int limit);
		logic prev;
		int   n;
		n = 0;
		prev = sync_level(use_v);
		tick();
		while (!(prev === 1'b1 && sync_level(use_v) === 1'b0)) begin
			if (n >= limit)
				fail_run($sformatf("%s did not fall within %0d clocks",
					use_v ? "vsync" : "hsync", limit));
			n++;
			prev = sync_level(use_v);
			tick();
		end
	endtask

	// vsync and hsync fall on the same clock at row 0
	task automatic frame_start();
		wait_fall(1'b1, FRAME_CLOCKS + `H_TOTAL);
		cur_line = 0;
	endtask

	task automatic next_line();
		wait_fall(1'b0, 2 * `H_TOTAL);
		cur_line = (cur_line + 1) % (2 * `V_ROWS);
	endtask

	task automatic goto_line(input int n);
		while (cur_line != n)
			next_line();
	endtask

	// from a falling edge: clocks low, then clocks to the next fall
	task automatic measure_pulse(input bit use_v, output int low, output int period);
		int start;
		start = cycles;
		low = 0;
		while (sync_level(use_v) === 1'b0 && low < FRAME_CLOCKS) begin
			low++;
			tick();
		end
		wait_fall(use_v, FRAME_CLOCKS + `H_TOTAL);
		period = cycles - start;
	endtask

	// walks one VGA line from its hsync fall, clock k is hcount k
	task automatic check_line(input int row, input logic [7:0] scr);
		bit         vwin;
		bit         vact;
		color_idx_t exp_idx;
		rgb_t       exp_rgb;
		vwin = (row >= `V_WIN_START) && (row < `V_WIN_END);
		vact = (row >= `V_ACT_START) && (row < `V_ACT_END);
		for (int k = 0; k < `H_TOTAL; k++) begin
			if (k > 0)
				tick();
			exp_idx = '0;
			exp_rgb = '0;
			if (vwin && k >= `H_WIN_START && k < `H_WIN_END) begin
				// each pixel spans two clocks
				if (vact && k >= `H_ACT_START && k < `H_ACT_END)
					exp_idx = expect_pixel(row, (k - `H_ACT_START) / 2, scr);
				else
					exp_idx = border_idx;
				exp_rgb = palette(exp_idx);
			end
			check($sformatf("coloridx row %0d clock %0d", row, k),
				32'(coloridx), 32'(exp_idx));
			check($sformatf("realcolor_out row %0d clock %0d", row, k),
				32'(realcolor_out), 32'(exp_rgb));
		end
	endtask

	task automatic check_row(input int row, input logic [7:0] scr, input bit both);
		goto_line(2 * row);
		check_line(row, scr);
		if (both) begin
			next_line();
			check_line(row, scr);
		end
	endtask

	// walks the row pair of row r, where the fetch of row r+1 runs
	// every slice taken must carry the next plane, then the next column
	task automatic check_fetch(input int row, input logic [7:0] scr);
		int          n;
		logic [7:0]  line;
		logic [15:0] exp_addr;
		logic [15:0] last;
		n = 0;
		last = '0;
		line = 8'(row + 1 - `V_ACT_START + int'(scr));
		goto_line(2 * row);
		for (int l = 0; l < 2; l++) begin
			if (l > 0)
				next_line();
			for (int k = 0; k < `H_TOTAL; k++) begin
				if (k > 0)
					tick();
				// a slice counts once the address has moved on to a new plane byte
				if (video_slice && sram_addr !== 16'd0 && sram_addr !== last) begin
					exp_addr = {3'(`PLANE_BASE + n % 4), 5'(n / 4), line};
					check($sformatf("sram_addr row %0d slice %0d", row, n),
						32'(sram_addr), 32'(exp_addr));
					last = sram_addr;
					n++;
				end
			end
		end
		// four planes for each of the 32 columns
		check($sformatf("sram_addr slices row %0d", row), n, 4 * 32);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic test_sync_timing();
		int low;
		int period;
		frame_start();
		measure_pulse(1'b1, low, period);
		check("vsync low clocks", low, 2 * `V_SYNC_ROWS * `H_TOTAL);
		check("vsync period", period, FRAME_CLOCKS);
		repeat (3) begin
			measure_pulse(1'b0, low, period);
			check("hsync low clocks", low, `H_SYNC);
			check("hsync period", period, `H_TOTAL);
		end
	endtask

	// one sample per row, taken at the even line
	task automatic test_retrace();
		bit exp;
		frame_start();
		for (int r = 0; r < `V_ROWS; r++) begin
			exp = (r < `V_ACT_START) || (r >= `V_ACT_END);
			check($sformatf("retrace row %0d", r), 32'(retrace), 32'(exp));
			next_line();
			next_line();
		end
	endtask

	task automatic test_border();
		int rows [9] = '{2, 7, 8, 39, 40, 295, 296, 303, 304};
		@(posedge clk24);
		border_idx <= 4'h9;
		frame_start();
		foreach (rows[i])
			check_row(rows[i], 8'h00, 1'b0);
	endtask

	task automatic test_pixels();
		int rows [8] = '{40, 41, 42, 99, 168, 255, 294, 295};
		frame_start();
		check_fetch(39, 8'h00);
		foreach (rows[i])
			check_row(rows[i], 8'h00, 1'b0);
	endtask

	// both lines of a row must show the same row
	task automatic test_scan_doubling();
		int rows [4] = '{40, 41, 133, 200};
		frame_start();
		foreach (rows[i])
			check_row(rows[i], 8'h00, 1'b1);
	endtask

	// a mid-frame write waits for the next frame
	task automatic test_scroll();
		frame_start();
		goto_line(2 * 120);
		@(posedge clk24);
		video_scroll_reg <= 8'h5c;
		check_row(150, 8'h00, 1'b0);
		check_row(295, 8'h00, 1'b0);
		frame_start();
		check_fetch(39, 8'h5c);
		check_row(40, 8'h5c, 1'b1);
		check_row(190, 8'h5c, 1'b0);
		check_row(295, 8'h5c, 1'b0);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		rst = 1'b1;
		video_scroll_reg = 8'h00;
		border_idx = 4'h0;
		mem_model.preload(seed);
		repeat (5) @(posedge clk24);
		rst <= 1'b0;
		test_sync_timing();
		test_retrace();
		test_border();
		test_pixels();
		test_scan_doubling();
		test_scroll();
		if (checks == 0) begin
			fail_run("no checks were run");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// File: vector_video.f
+incdir+include
design/video_pkg.sv
design/vga_refresh.sv
design/framebuffer.sv
design/line_buffer.sv
design/scan_doubler.sv
design/video_top.sv
tests/sram_model.sv
tests/tb_video.sv
